// ==== src.f ====
+incdir+verilog
verilog/axil_pkg.sv
verilog/axil_arbiter_2x1.sv
verilog/axil_sram.sv
verilog/axil_mem_subsys.sv
bench/axil_checker.sv
bench/tb_axil_mem_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the memory port testbench with Verilator, run it and report the result
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
    --top-module tb_axil_mem_subsys -Mdir obj_dir -f src.f; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vtb_axil_mem_subsys)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION PASSED" <<< "$output"; then
  exit 0
fi
exit 1

// ==== bench/tb_axil_mem_subsys.sv ====
// Testbench top for the memory port, two random AXI-lite masters against the DUT and checker
`timescale 1ns/1ns
`default_nettype none

`include "axil_defines.svh"

module tb_axil_mem_subsys;

  localparam int          TXNS_EACH  = 200;               // 400 over both masters
  localparam int          WAIT_LIMIT = 64;
  localparam int          WORD_SPAN  = `SRAM_WORDS + 16;  // Top 16 words out of range
  localparam logic [31:0] SEED       = 32'he120_7590;

  logic                         aclk;
  logic                         rst_n;
  logic [1:0]                   awvalid, awready, wvalid, wready;
  logic [1:0]                   bvalid, bready;
  logic [1:0]                   arvalid, arready, rvalid, rready;
  axil_pkg::axil_ax_t [1:0]     aw, ar;
  axil_pkg::axil_w_t [1:0]      w;
  logic [1:0][1:0]              bresp;
  axil_pkg::axil_r_t [1:0]      r;
  logic [31:0]                  err_count;
  logic [31:0]                  check_count;
  logic [31:0]                  lfsr_state [2];  // One stream per master
  int                           timeouts;

  always #20 aclk = ~aclk;

  // Index 0 is master A, index 1 is master B
  axil_mem_subsys DUT (
    .i_aclk (aclk), .i_rst_n (rst_n),
    .i_a_awvalid (awvalid[0]), .o_a_awready (awready[0]), .i_a_aw (aw[0]),
    .i_a_wvalid (wvalid[0]), .o_a_wready (wready[0]), .i_a_w (w[0]),
    .o_a_bvalid (bvalid[0]), .i_a_bready (bready[0]), .o_a_bresp (bresp[0]),
    .i_a_arvalid (arvalid[0]), .o_a_arready (arready[0]), .i_a_ar (ar[0]),
    .o_a_rvalid (rvalid[0]), .i_a_rready (rready[0]), .o_a_r (r[0]),
    .i_b_awvalid (awvalid[1]), .o_b_awready (awready[1]), .i_b_aw (aw[1]),
    .i_b_wvalid (wvalid[1]), .o_b_wready (wready[1]), .i_b_w (w[1]),
    .o_b_bvalid (bvalid[1]), .i_b_bready (bready[1]), .o_b_bresp (bresp[1]),
    .i_b_arvalid (arvalid[1]), .o_b_arready (arready[1]), .i_b_ar (ar[1]),
    .o_b_rvalid (rvalid[1]), .i_b_rready (rready[1]), .o_b_r (r[1])
  );

  axil_checker u_checker (
    .i_aclk (aclk), .i_rst_n (rst_n),
    .i_awvalid (awvalid), .i_awready (awready), .i_aw (aw),
    .i_wvalid (wvalid), .i_wready (wready), .i_w (w),
    .i_bvalid (bvalid), .i_bready (bready), .i_bresp (bresp),
    .i_arvalid (arvalid), .i_arready (arready), .i_ar (ar),
    .i_rvalid (rvalid), .i_rready (rready), .i_r (r),
    .o_errors (err_count), .o_checks (check_count)
  );

  // Galois LFSR x^32 + x^22 + x^2 + x + 1, one step per bit drawn
  function automatic logic [63:0] rand_bits(input int m, input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_state[m][0]};
      lfsr_state[m] = (lfsr_state[m] >> 1) ^ (lfsr_state[m][0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  task automatic note_timeout(input int m, input string what);
    timeouts++;
    $display("Timeout: master %0d saw no %s within %0d cycles", m, what, WAIT_LIMIT);
  endtask

  // ----------------------------------------------------------------------
  // Master handshakes
  // ----------------------------------------------------------------------
  task automatic await_accept(input int m, input bit rd, output bit ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < WAIT_LIMIT) begin
      @(posedge aclk);
      cycles++;
      ok = rd ? arready[m] : awready[m];
    end
    arvalid[m] <= rd ? 1'b0 : arvalid[m];
    awvalid[m] <= rd ? awvalid[m] : 1'b0;
    wvalid[m]  <= rd ? wvalid[m] : 1'b0;
    if (!ok) begin
      note_timeout(m, rd ? "read address ready" : "write address ready");
    end
  endtask

  task automatic await_response(input int m, input bit rd, output bit ok);
    int   cycles;
    logic rdy;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < WAIT_LIMIT) begin
      rdy = rand_bits(m, 2) != 64'd0;  // Low about one cycle in four
      rready[m] <= rd ? rdy : 1'b0;
      bready[m] <= rd ? 1'b0 : rdy;
      @(posedge aclk);
      cycles++;
      ok = rd ? (rvalid[m] && rready[m]) : (bvalid[m] && bready[m]);
    end
    rready[m] <= 1'b0;
    bready[m] <= 1'b0;
    if (!ok) begin
      note_timeout(m, rd ? "read response" : "write response");
    end
  endtask

  task automatic run_master(input int m);
    logic [31:0] idx;
    bit          rd;
    bit          ok;
    ok = 1'b1;
    for (int t = 0; t < TXNS_EACH && ok; t++) begin
      repeat (int'(rand_bits(m, 2)) + 1) @(posedge aclk);
      idx = 32'(rand_bits(m, 9)) % WORD_SPAN;
      rd  = 1'(rand_bits(m, 1));
      if (rd) begin
        ar[m]      <= '{addr: idx << 3, prot: 3'(rand_bits(m, 3))};
        arvalid[m] <= 1'b1;
      end else begin
        aw[m]      <= '{addr: idx << 3, prot: 3'(rand_bits(m, 3))};
        w[m]       <= '{data: rand_bits(m, 64), strb: 8'(rand_bits(m, 8))};
        awvalid[m] <= 1'b1;  // AW and W go up together
        wvalid[m]  <= 1'b1;
      end
      await_accept(m, rd, ok);
      if (ok) begin
        await_response(m, rd, ok);
      end
    end
  endtask

  initial begin
    aclk  = 1'b0;
    rst_n = 1'b0;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    aw       = '0;
    w        = '0;
    ar       = '0;
    timeouts = 0;
    lfsr_state[0] = SEED;
    lfsr_state[1] = SEED;
    void'(rand_bits(1, 61));  // Offset B so it does not mirror A
    repeat (5) @(posedge aclk);
    rst_n <= 1'b1;
    repeat (2) @(posedge aclk);  // First cycle after release stays idle
    fork
      run_master(0);
      run_master(1);
    join
    repeat (2) @(posedge aclk);
    $display("Checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeouts);
    if (err_count == 0 && timeouts == 0 && check_count > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/axil_checker.sv ====
// Testbench monitor on both master ports, compares against a shadow memory and counts errors
`timescale 1ns/1ns
`default_nettype none

`include "axil_defines.svh"

module axil_checker (
  input  wire                            i_aclk,
  input  wire                            i_rst_n,
  input  wire [1:0]                      i_awvalid,
  input  wire [1:0]                      i_awready,
  input  wire axil_pkg::axil_ax_t [1:0]  i_aw,
  input  wire [1:0]                      i_wvalid,
  input  wire [1:0]                      i_wready,
  input  wire axil_pkg::axil_w_t [1:0]   i_w,
  input  wire [1:0]                      i_bvalid,
  input  wire [1:0]                      i_bready,
  input  wire [1:0][1:0]                 i_bresp,
  input  wire [1:0]                      i_arvalid,
  input  wire [1:0]                      i_arready,
  input  wire axil_pkg::axil_ax_t [1:0]  i_ar,
  input  wire [1:0]                      i_rvalid,
  input  wire [1:0]                      i_rready,
  input  wire axil_pkg::axil_r_t [1:0]   i_r,
  output logic [31:0]                    o_errors,
  output logic [31:0]                    o_checks
);

  logic [`AXIL_DATA_W-1:0] shadow [`SRAM_WORDS];
  logic [`AXIL_STRB_W-1:0] known [`SRAM_WORDS];  // Lanes written since reset
  logic                    wr_open;              // Write between AW and B
  logic                    rd_open;
  int                      wr_who;
  int                      rd_who;
  logic                    after_rst;
  logic [1:0]              want_bresp;
  logic [1:0]              want_rresp;
  logic [`AXIL_DATA_W-1:0] want_rdata;
  logic [`AXIL_DATA_W-1:0] want_rmask;  // Only known lanes are compared

  function automatic logic [`AXIL_DATA_W-1:0] lane_mask(input logic [`AXIL_STRB_W-1:0] strb);
    logic [`AXIL_DATA_W-1:0] mask;
    for (int i = 0; i < `AXIL_STRB_W; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

  task automatic expect_eq(input string what, input int m, input logic [63:0] got,
                           input logic [63:0] want);
    o_checks++;
    if (got !== want) begin
      o_errors++;
      $display("[FAIL] %0t ns: master %0d %s, got %0h, expected %0h", $time, m, what, got, want);
    end
  endtask

  // --------------------------------------------------------------------
  // Per-edge comparison
  // --------------------------------------------------------------------
  always @(posedge i_aclk) begin
    logic [1:0] want_awr;
    logic [1:0] want_arr;
    int         word;
    if (!i_rst_n) begin
      wr_open   = 1'b0;
      rd_open   = 1'b0;
      after_rst = 1'b1;
      o_errors  = '0;
      o_checks  = '0;
      for (int i = 0; i < `SRAM_WORDS; i++) begin
        known[i] = '0;
      end
    end else begin
      if (after_rst) begin
        expect_eq("ready or valid after reset", 0,
                  64'({i_awready, i_wready, i_arready, i_bvalid, i_rvalid}), 64'd0);
        after_rst = 1'b0;
      end
      // A first, and nobody while the direction is open
      want_awr = 2'b00;
      want_arr = 2'b00;
      if (!wr_open) begin
        want_awr[0] = i_awvalid[0] & i_wvalid[0];
        want_awr[1] = ~i_awvalid[0] & i_awvalid[1] & i_wvalid[1];
      end
      if (!rd_open) begin
        want_arr[0] = i_arvalid[0];
        want_arr[1] = ~i_arvalid[0] & i_arvalid[1];
      end
      for (int m = 0; m < 2; m++) begin
        expect_eq("awready", m, 64'(i_awready[m]), 64'(want_awr[m]));
        expect_eq("wready", m, 64'(i_wready[m]), 64'(want_awr[m]));
        expect_eq("arready", m, 64'(i_arready[m]), 64'(want_arr[m]));
        // Owner only, from the cycle after its address transfer on
        expect_eq("bvalid", m, 64'(i_bvalid[m]), 64'(wr_open && wr_who == m));
        expect_eq("rvalid", m, 64'(i_rvalid[m]), 64'(rd_open && rd_who == m));
      end

      if (wr_open && i_bvalid[wr_who] && i_bready[wr_who]) begin
        expect_eq("bresp", wr_who, 64'(i_bresp[wr_who]), 64'(want_bresp));
        wr_open = 1'b0;
      end
      if (rd_open && i_rvalid[rd_who] && i_rready[rd_who]) begin
        expect_eq("rresp", rd_who, 64'(i_r[rd_who].resp), 64'(want_rresp));
        expect_eq("rdata", rd_who, i_r[rd_who].data & want_rmask, want_rdata & want_rmask);
        rd_open = 1'b0;
      end

      // Reads capture before this edge's write lands
      for (int m = 0; m < 2; m++) begin
        if (i_arvalid[m] && i_arready[m]) begin
          word    = int'(i_ar[m].addr >> 3);
          rd_open = 1'b1;
          rd_who  = m;
          if (word < `SRAM_WORDS) begin
            want_rdata = shadow[word];
            want_rmask = lane_mask(known[word]);
            want_rresp = axil_pkg::OKAY;
          end else begin
            want_rdata = '0;
            want_rmask = '1;
            want_rresp = axil_pkg::SLVERR;
          end
        end
      end
      for (int m = 0; m < 2; m++) begin
        if (i_awvalid[m] && i_awready[m]) begin
          word    = int'(i_aw[m].addr >> 3);
          wr_open = 1'b1;
          wr_who  = m;
          if (word < `SRAM_WORDS) begin
            want_bresp   = axil_pkg::OKAY;
            shadow[word] = (shadow[word] & ~lane_mask(i_w[m].strb)) |
                           (i_w[m].data & lane_mask(i_w[m].strb));
            known[word]  = known[word] | i_w[m].strb;
          end else begin
            want_bresp = axil_pkg::SLVERR;  // Memory untouched
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/axil_mem_subsys.sv ====
// Memory port top level, two AXI-lite masters arbitrated onto the on-chip SRAM
`timescale 1ns/1ns
`default_nettype none

module axil_mem_subsys (
  input  wire                 i_aclk,
  input  wire                 i_rst_n,

  // Master A, usually instruction fetch
  input  wire                 i_a_awvalid,
  output logic                o_a_awready,
  input  axil_pkg::axil_ax_t  i_a_aw,
  input  wire                 i_a_wvalid,
  output logic                o_a_wready,
  input  axil_pkg::axil_w_t   i_a_w,
  output logic                o_a_bvalid,
  input  wire                 i_a_bready,
  output axil_pkg::resp_e     o_a_bresp,
  input  wire                 i_a_arvalid,
  output logic                o_a_arready,
  input  axil_pkg::axil_ax_t  i_a_ar,
  output logic                o_a_rvalid,
  input  wire                 i_a_rready,
  output axil_pkg::axil_r_t   o_a_r,

  // Master B, usually load/store
  input  wire                 i_b_awvalid,
  output logic                o_b_awready,
  input  axil_pkg::axil_ax_t  i_b_aw,
  input  wire                 i_b_wvalid,
  output logic                o_b_wready,
  input  axil_pkg::axil_w_t   i_b_w,
  output logic                o_b_bvalid,
  input  wire                 i_b_bready,
  output axil_pkg::resp_e     o_b_bresp,
  input  wire                 i_b_arvalid,
  output logic                o_b_arready,
  input  axil_pkg::axil_ax_t  i_b_ar,
  output logic                o_b_rvalid,
  input  wire                 i_b_rready,
  output axil_pkg::axil_r_t   o_b_r
);

  // ----------------------------------------------------------------------
  // Arbiter to SRAM link
  // ----------------------------------------------------------------------
  logic               awvalid, awready;
  axil_pkg::axil_ax_t aw;
  logic               wvalid, wready;
  axil_pkg::axil_w_t  w;
  logic               bvalid, bready;
  axil_pkg::resp_e    bresp;
  logic               arvalid, arready;
  axil_pkg::axil_ax_t ar;
  logic               rvalid, rready;
  axil_pkg::axil_r_t  r;

  // Upstream names match the top ports one to one
  axil_arbiter_2x1 u_arbiter (
    .*,
    .o_awvalid (awvalid),
    .i_awready (awready),
    .o_aw      (aw),
    .o_wvalid  (wvalid),
    .i_wready  (wready),
    .o_w       (w),
    .i_bvalid  (bvalid),
    .o_bready  (bready),
    .i_bresp   (bresp),
    .o_arvalid (arvalid),
    .i_arready (arready),
    .o_ar      (ar),
    .i_rvalid  (rvalid),
    .o_rready  (rready),
    .i_r       (r)
  );

  axil_sram u_sram (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_aw      (aw),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .i_w       (w),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .o_bresp   (bresp),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_ar      (ar),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_r       (r)
  );

endmodule

`default_nettype wire

// ==== verilog/axil_sram.sv ====
// AXI-lite slave over a byte-strobed word SRAM with one-cycle responses and SLVERR past the top
`timescale 1ns/1ns
`default_nettype none

`include "axil_defines.svh"

module axil_sram (
  input  wire                 i_aclk,
  input  wire                 i_rst_n,

  input  wire                 i_awvalid,
  output logic                o_awready,
  input  axil_pkg::axil_ax_t  i_aw,
  input  wire                 i_wvalid,
  output logic                o_wready,
  input  axil_pkg::axil_w_t   i_w,
  output logic                o_bvalid,
  input  wire                 i_bready,
  output axil_pkg::resp_e     o_bresp,
  input  wire                 i_arvalid,
  output logic                o_arready,
  input  axil_pkg::axil_ax_t  i_ar,
  output logic                o_rvalid,
  input  wire                 i_rready,
  output axil_pkg::axil_r_t   o_r
);

  localparam int IDX_W = $clog2(`SRAM_WORDS);

  logic [`AXIL_DATA_W-1:0] mem [`SRAM_WORDS];

  logic [`AXIL_ADDR_W-4:0] aw_word;   // Byte address with lane bits dropped
  logic [`AXIL_ADDR_W-4:0] ar_word;
  logic                    aw_ok;
  logic                    ar_ok;
  logic                    wr_fire;
  logic                    rd_fire;
  logic                    bvalid_q;
  logic                    rvalid_q;
  axil_pkg::resp_e         bresp_q;
  axil_pkg::axil_r_t       r_q;

  assign aw_word = i_aw.addr[`AXIL_ADDR_W-1:3];
  assign ar_word = i_ar.addr[`AXIL_ADDR_W-1:3];
  assign aw_ok   = aw_word < (`AXIL_ADDR_W-3)'(`SRAM_WORDS);
  assign ar_ok   = ar_word < (`AXIL_ADDR_W-3)'(`SRAM_WORDS);

  // ----------------------------------------------------------------------
  // Handshakes
  // ----------------------------------------------------------------------
  // AW and W are only ever taken together
  assign o_awready = i_awvalid & i_wvalid & ~bvalid_q;
  assign o_wready  = i_awvalid & i_wvalid & ~bvalid_q;
  assign o_arready = ~rvalid_q;

  assign wr_fire = i_awvalid & o_awready;
  assign rd_fire = i_arvalid & o_arready;

  assign o_bvalid = bvalid_q;
  assign o_bresp  = bresp_q;
  assign o_rvalid = rvalid_q;
  assign o_r      = r_q;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (i_bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (i_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Array and response payloads
  // ----------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (wr_fire && aw_ok) begin
      for (int i = 0; i < `AXIL_STRB_W; i++) begin
        if (i_w.strb[i]) begin
          mem[aw_word[IDX_W-1:0]][8*i +: 8] <= i_w.data[8*i +: 8];
        end
      end
    end
  end

  // Read samples the array before a same-edge write lands
  always_ff @(posedge i_aclk) begin
    if (wr_fire) begin
      bresp_q <= aw_ok ? axil_pkg::OKAY : axil_pkg::SLVERR;
    end
    if (rd_fire) begin
      r_q.data <= ar_ok ? mem[ar_word[IDX_W-1:0]] : '0;
      r_q.resp <= ar_ok ? axil_pkg::OKAY : axil_pkg::SLVERR;
    end
  end

  // Masters must raise W along with AW
  a_aw_with_w : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_awvalid |-> i_wvalid);

endmodule

`default_nettype wire

// ==== verilog/axil_arbiter_2x1.sv ====
// Two-master AXI-lite arbiter where A has priority and each direction's grant holds until the response
`timescale 1ns/1ns
`default_nettype none

module axil_arbiter_2x1 (
  input  wire                 i_aclk,
  input  wire                 i_rst_n,

  // --------------------------------------------------------------------
  // Master A
  // --------------------------------------------------------------------
  input  wire                 i_a_awvalid,
  output logic                o_a_awready,
  input  axil_pkg::axil_ax_t  i_a_aw,
  input  wire                 i_a_wvalid,
  output logic                o_a_wready,
  input  axil_pkg::axil_w_t   i_a_w,
  output logic                o_a_bvalid,
  input  wire                 i_a_bready,
  output axil_pkg::resp_e     o_a_bresp,
  input  wire                 i_a_arvalid,
  output logic                o_a_arready,
  input  axil_pkg::axil_ax_t  i_a_ar,
  output logic                o_a_rvalid,
  input  wire                 i_a_rready,
  output axil_pkg::axil_r_t   o_a_r,

  // --------------------------------------------------------------------
  // Master B
  // --------------------------------------------------------------------
  input  wire                 i_b_awvalid,
  output logic                o_b_awready,
  input  axil_pkg::axil_ax_t  i_b_aw,
  input  wire                 i_b_wvalid,
  output logic                o_b_wready,
  input  axil_pkg::axil_w_t   i_b_w,
  output logic                o_b_bvalid,
  input  wire                 i_b_bready,
  output axil_pkg::resp_e     o_b_bresp,
  input  wire                 i_b_arvalid,
  output logic                o_b_arready,
  input  axil_pkg::axil_ax_t  i_b_ar,
  output logic                o_b_rvalid,
  input  wire                 i_b_rready,
  output axil_pkg::axil_r_t   o_b_r,

  // --------------------------------------------------------------------
  // Downstream slave
  // --------------------------------------------------------------------
  output logic                o_awvalid,
  input  wire                 i_awready,
  output axil_pkg::axil_ax_t  o_aw,
  output logic                o_wvalid,
  input  wire                 i_wready,
  output axil_pkg::axil_w_t   o_w,
  input  wire                 i_bvalid,
  output logic                o_bready,
  input  axil_pkg::resp_e     i_bresp,
  output logic                o_arvalid,
  input  wire                 i_arready,
  output axil_pkg::axil_ax_t  o_ar,
  input  wire                 i_rvalid,
  output logic                o_rready,
  input  axil_pkg::axil_r_t   i_r
);

  logic wr_lock;     // Write in flight
  logic wr_owner;    // 0 for A, 1 for B
  logic rd_lock;
  logic rd_owner;
  logic aw_gnt_a, aw_gnt_b;
  logic ar_gnt_a, ar_gnt_b;
  logic b_to_a, b_to_b;
  logic r_to_a, r_to_b;
  logic aw_fire, b_fire;
  logic ar_fire, r_fire;

  // ----------------------------------------------------------------------
  // Write direction
  // ----------------------------------------------------------------------
  // Priority only matters while no write is locked
  assign aw_gnt_a = ~wr_lock & i_a_awvalid;
  assign aw_gnt_b = ~wr_lock & ~i_a_awvalid & i_b_awvalid;

  assign o_awvalid   = aw_gnt_a | aw_gnt_b;
  assign o_aw        = aw_gnt_b ? i_b_aw : i_a_aw;
  assign o_wvalid    = (aw_gnt_a & i_a_wvalid) | (aw_gnt_b & i_b_wvalid);
  assign o_w         = aw_gnt_b ? i_b_w : i_a_w;
  assign o_a_awready = aw_gnt_a & i_awready;
  assign o_b_awready = aw_gnt_b & i_awready;
  assign o_a_wready  = aw_gnt_a & i_wready;
  assign o_b_wready  = aw_gnt_b & i_wready;

  // B goes back only to the locked owner
  assign b_to_a     = wr_lock & ~wr_owner;
  assign b_to_b     = wr_lock &  wr_owner;
  assign o_a_bvalid = i_bvalid & b_to_a;
  assign o_b_bvalid = i_bvalid & b_to_b;
  assign o_bready   = (b_to_a & i_a_bready) | (b_to_b & i_b_bready);
  assign o_a_bresp  = b_to_a ? i_bresp : axil_pkg::OKAY;  // Zero toward the idle side
  assign o_b_bresp  = b_to_b ? i_bresp : axil_pkg::OKAY;

  assign aw_fire = o_awvalid & i_awready;  // W moves in the same cycle
  assign b_fire  = i_bvalid & o_bready;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      wr_lock  <= 1'b0;
      wr_owner <= 1'b0;
    end else if (aw_fire) begin
      wr_lock  <= 1'b1;
      wr_owner <= aw_gnt_b;
    end else if (b_fire) begin
      wr_lock  <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // Read direction
  // ----------------------------------------------------------------------
  assign ar_gnt_a = ~rd_lock & i_a_arvalid;
  assign ar_gnt_b = ~rd_lock & ~i_a_arvalid & i_b_arvalid;

  assign o_arvalid   = ar_gnt_a | ar_gnt_b;
  assign o_ar        = ar_gnt_b ? i_b_ar : i_a_ar;
  assign o_a_arready = ar_gnt_a & i_arready;
  assign o_b_arready = ar_gnt_b & i_arready;

  assign r_to_a     = rd_lock & ~rd_owner;
  assign r_to_b     = rd_lock &  rd_owner;
  assign o_a_rvalid = i_rvalid & r_to_a;
  assign o_b_rvalid = i_rvalid & r_to_b;
  assign o_rready   = (r_to_a & i_a_rready) | (r_to_b & i_b_rready);
  assign o_a_r      = r_to_a ? i_r : '0;
  assign o_b_r      = r_to_b ? i_r : '0;

  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = i_rvalid & o_rready;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      rd_lock  <= 1'b0;
      rd_owner <= 1'b0;
    end else if (ar_fire) begin
      rd_lock  <= 1'b1;
      rd_owner <= ar_gnt_b;
    end else if (r_fire) begin
      rd_lock  <= 1'b0;
    end
  end

  // Slave must only answer something this arbiter forwarded
  a_b_needs_lock : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_bvalid |-> wr_lock);
  a_r_needs_lock : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_rvalid |-> rd_lock);

endmodule

`default_nettype wire

// ==== verilog/axil_pkg.sv ====
// AXI-lite channel payload types and response codes shared by the arbiter, SRAM and top level
`default_nettype none

`include "axil_defines.svh"

package axil_pkg;

  // --------------------------------------------------------------------
  // Response codes
  // --------------------------------------------------------------------
  // Only the two codes the SRAM can produce
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2
  } resp_e;

  // --------------------------------------------------------------------
  // Channel payloads
  // --------------------------------------------------------------------
  // Valid and ready travel on their own ports, so these are payload only

  // Address channel, same shape for AW and AR
  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;   // Byte address
    logic [2:0]              prot;   // Carried through, not decoded
  } axil_ax_t;

  // Write data channel
  typedef struct packed {
    logic [`AXIL_DATA_W-1:0] data;
    logic [`AXIL_STRB_W-1:0] strb;   // Bit i enables byte lane i
  } axil_w_t;

  // Read data channel
  typedef struct packed {
    logic [`AXIL_DATA_W-1:0] data;
    resp_e                   resp;
  } axil_r_t;

  // The B channel has no struct of its own: it is a bare resp_e

endpackage

`default_nettype wire

// ==== verilog/axil_defines.svh ====
// Bus widths and SRAM depth for the AXI-lite memory port, included wherever sizes are needed
`ifndef AXIL_DEFINES_SVH
`define AXIL_DEFINES_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 64
`define AXIL_STRB_W (`AXIL_DATA_W / 8)  // One strobe per byte lane

// ----------------------------------------------------------------------
// On-chip SRAM
// ----------------------------------------------------------------------
// Depth in 64-bit words. Byte addresses from 8 * SRAM_WORDS upward
// fall outside the array and get SLVERR
`define SRAM_WORDS 256

`endif
